// ==== project.f ====
+incdir+hw
hw/syscfg_pkg.sv
hw/pause_demux.sv
hw/syscfg_tgt.sv
hw/core_stub.sv
hw/syscfg_top.sv
bench/tb_syscfg.sv

// ==== Makefile ====
TOP = tb_syscfg

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

obj_dir/V$(TOP): project.f $(wildcard hw/*.sv hw/*.svh bench/*.sv)
	verilator --binary --timing -f project.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== bench/syscfg_cases.txt ====
# op idx data strb exp_data exp_err core_chk core_val (all but op in hex)
# core_chk 0 none, 1 running on core_val grid, 2 halted, 3 held in reset at core_val
poll 0 00000003 f 00000000 0 1 00000000
rd 0 00000000 f 00000000 0 0 00000000
rd 1 00000000 f 00000000 0 0 00000000
wr 2 12345678 f 00000000 0 0 00000000
rd 2 00000000 f 12345678 0 0 00000000
wr 2 aabbccdd 5 00000000 0 0 00000000
rd 2 00000000 f 12bb56dd 0 0 00000000
wr 0 00000003 f 00000000 1 0 00000000
rd 5 00000000 f 00000000 1 0 00000000
rd 3 00000000 f 00000000 0 0 00000000
wr 1 00000002 1 00000000 0 0 00000000
poll 0 00000001 f 00000001 0 2 00000000
rd 1 00000000 f 00000000 0 0 00000000
rd 0 00000000 f 00000001 0 2 00000000
wr 1 00000001 1 00000000 0 0 00000000
poll 0 00000001 f 00000000 0 1 00000000
wr 1 00000002 e 00000000 0 1 00000000
rd 0 00000000 f 00000000 0 0 00000000
wr 1 00000003 1 00000000 0 0 00000000
poll 0 00000003 f 00000003 0 3 12bb56dd
rd 1 00000000 f 00000000 0 0 00000000
wr 2 00002002 f 00000000 0 3 00002002
rd 2 00000000 f 00002002 0 0 00000000
wr 1 00000004 1 00000000 0 0 00000000
poll 0 00000003 f 00000000 0 1 00002002
wr 3 0000f0f1 f 00000000 0 0 00000000
rd 3 00000000 f 0000f0f1 0 0 00000000
irq 0 00000001 0 00000001 0 0 00000000
irq 0 0000000e 0 00000000 0 0 00000000
irq 0 00000f00 0 00000000 0 0 00000000
irq 0 00001000 0 00000001 0 0 00000000
irq 0 ffff0000 0 00000000 0 0 00000000
wr 3 ffff0000 c 00000000 0 0 00000000
rd 3 00000000 f fffff0f1 0 0 00000000
irq 0 00200000 0 00000001 0 0 00000000
irq 0 00000000 0 00000000 0 0 00000000
spause 0 00000000 0 00000000 0 1 00002002
sresume 2 00000000 f 00002002 0 0 00000000
spause 0 00000000 0 00000000 0 0 00000000
sresume 3 00000000 f fffff0f1 0 1 00002002
wr 1 00000002 1 00000000 0 0 00000000
poll 0 00000001 f 00000001 0 2 00000000

// ==== bench/tb_syscfg.sv ====
`include "syscfg_defs.svh"

module tb_syscfg import syscfg_pkg::*; ();

    localparam int    CLK_PERIOD = 40;
    localparam int    POLL_LIMIT = 64;
    localparam int    PC_GAP     = 4;
    localparam int    STRB_W     = `SYSCFG_DATA_WIDTH / 8;
    localparam string CASES_FILE = "bench/syscfg_cases.txt";

    logic  seq;
    logic  arst_n;
    addr_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    data_t pwdata;
    strb_t pstrb;
    logic  pready;
    data_t prdata;
    logic  pslverr;
    logic  pause_req;
    logic  pause_ack;
    data_t irq_vec;
    logic  irq;
    addr_t core_pc;
    logic  core_rst;

    // One case table entry per line of the cases file
    string       q_op[$];
    logic [31:0] q_idx[$];
    logic [31:0] q_data[$];
    logic [31:0] q_strb[$];
    logic [31:0] q_exp[$];
    logic [31:0] q_err[$];
    logic [31:0] q_chk[$];
    logic [31:0] q_val[$];

    bit loaded;
    int err_count;
    int check_count;
    int fail_cases;

    syscfg_top i_dut (
        .seq      (seq),
        .arst_n   (arst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .pready   (pready),
        .prdata   (prdata),
        .pslverr  (pslverr),
        .pause_req(pause_req),
        .pause_ack(pause_ack),
        .irq_vec  (irq_vec),
        .irq      (irq),
        .core_pc  (core_pc),
        .core_rst (core_rst)
    );

    initial begin
        seq = 1'b0;
        forever #(CLK_PERIOD / 2) seq = ~seq;
    end

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("ERR %s: got 0x%08h expected 0x%08h", name, actual, expected);
            err_count++;
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        string       op;
        logic [31:0] v_idx;
        logic [31:0] v_data;
        logic [31:0] v_strb;
        logic [31:0] v_exp;
        logic [31:0] v_err;
        logic [31:0] v_chk;
        logic [31:0] v_val;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the cases file %s", CASES_FILE);
            err_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h", op, v_idx, v_data, v_strb,
                        v_exp, v_err, v_chk, v_val);
            if (n <= 0) begin
                continue;
            end
            if (n != 8) begin
                $display("Malformed line in the cases file: %s", line);
                err_count++;
            end else begin
                q_op.push_back(op);
                q_idx.push_back(v_idx);
                q_data.push_back(v_data);
                q_strb.push_back(v_strb);
                q_exp.push_back(v_exp);
                q_err.push_back(v_err);
                q_chk.push_back(v_chk);
                q_val.push_back(v_val);
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_gap();
        repeat ($urandom % 4) @(negedge seq);
    endtask

    // Setup phase then access phase on the next falling edge
    task automatic apb_start(input logic [31:0] idx, input logic wr,
                             input logic [31:0] data, input logic [31:0] strb);
        @(negedge seq);
        paddr   = idx * STRB_W;
        pwrite  = wr;
        pwdata  = data;
        pstrb   = strb[STRB_W-1:0];
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge seq);
        penable = 1'b1;
    endtask

    task automatic apb_finish(output logic [31:0] rdata, output logic err);
        while (!pready) @(negedge seq);
        rdata = prdata;
        err   = pslverr;
        @(negedge seq);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_core(input logic [31:0] chk, input logic [31:0] val);
        addr_t pc_a;
        addr_t pc_b;
        if (chk == 0) begin
            return;
        end
        @(negedge seq);
        pc_a = core_pc;
        repeat (PC_GAP) @(negedge seq);
        pc_b = core_pc;
        case (chk)
            1: begin
                check_val("core_rst", 32'(core_rst), 32'd0);
                check_val("core_pc advance", pc_b - pc_a, PC_GAP * `SYSCFG_PC_STEP);
                // Offset from the boot address lands on the fetch grid
                check_val("core_pc offset", (pc_b - val) % `SYSCFG_PC_STEP, 32'd0);
            end
            2: check_val("core_pc", pc_b, pc_a);
            3: begin
                check_val("core_rst", 32'(core_rst), 32'd1);
                check_val("core_pc", pc_b, val);
            end
            default: begin
                $display("Unknown core check code %0d", chk);
                err_count++;
            end
        endcase
    endtask

    task automatic run_case(input int i);
        string       op;
        logic [31:0] rdata;
        logic        err;
        int          tries;
        bit          matched;
        op = q_op[i];
        if (op == "rd") begin
            apb_start(q_idx[i], 1'b0, 32'd0, q_strb[i]);
            apb_finish(rdata, err);
            check_val("prdata", rdata, q_exp[i]);
            check_val("pslverr", 32'(err), q_err[i]);
        end else if (op == "wr") begin
            apb_start(q_idx[i], 1'b1, q_data[i], q_strb[i]);
            apb_finish(rdata, err);
            check_val("pslverr", 32'(err), q_err[i]);
        end else if (op == "poll") begin
            matched = 1'b0;
            tries   = 0;
            err     = 1'b0;
            while (!matched && tries < POLL_LIMIT) begin
                apb_start(q_idx[i], 1'b0, 32'd0, q_strb[i]);
                apb_finish(rdata, err);
                tries++;
                if ((rdata & q_data[i]) == q_exp[i]) begin
                    matched = 1'b1;
                end else begin
                    idle_gap();
                end
            end
            if (!matched) begin
                $display("Poll of index %0d never showed 0x%08h under mask 0x%08h",
                         q_idx[i], q_exp[i], q_data[i]);
                err_count++;
            end
            check_val("pslverr", 32'(err), q_err[i]);
        end else if (op == "irq") begin
            @(negedge seq);
            irq_vec = q_data[i];
            @(negedge seq);
            check_val("irq", 32'(irq), q_exp[i]);
        end else if (op == "spause") begin
            @(negedge seq);
            pause_req = 1'b1;
            while (!pause_ack) @(negedge seq);
            check_val("pready", 32'(pready), 32'd0);
        end else if (op == "sresume") begin
            // Read issued while paused must stall until the pause is released
            apb_start(q_idx[i], 1'b0, 32'd0, q_strb[i]);
            repeat (4) begin
                check_val("pready", 32'(pready), 32'd0);
                @(negedge seq);
            end
            pause_req = 1'b0;
            apb_finish(rdata, err);
            check_val("prdata", rdata, q_exp[i]);
            check_val("pslverr", 32'(err), q_err[i]);
            while (pause_ack) @(negedge seq);
        end else begin
            $display("Unknown operation %s in case %0d", op, i);
            err_count++;
        end
        check_core(q_chk[i], q_val[i]);
    endtask

    initial begin
        int errs_before;
        arst_n    = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pstrb     = '0;
        pause_req = 1'b0;
        irq_vec   = '0;
        void'($urandom(32'he433_cc29));
        load_cases();
        loaded = 1'b1;
        repeat (3) @(posedge seq);
        @(negedge seq);
        arst_n = 1'b1;
        for (int i = 0; i < q_op.size(); i++) begin
            errs_before = err_count;
            run_case(i);
            if (err_count == errs_before) begin
                $display("case %0d %s idx %0h: ok", i, q_op[i], q_idx[i]);
            end else begin
                $display("case %0d %s idx %0h: failed", i, q_op[i], q_idx[i]);
                fail_cases++;
            end
            idle_gap();
        end
        $display("%0d cases, %0d failed, %0d checks, %0d errors",
                 q_op.size(), fail_cases, check_count, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized from the number of cases
    initial begin
        wait (loaded);
        #((q_op.size() + 1) * 200 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles",
                 (q_op.size() + 1) * 200);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== hw/syscfg_top.sv ====
module syscfg_top import syscfg_pkg::*; (
    input  logic  seq,
    input  logic  arst_n,

    input  addr_t paddr,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  data_t pwdata,
    input  strb_t pstrb,
    output logic  pready,
    output data_t prdata,
    output logic  pslverr,

    input  logic  pause_req,
    output logic  pause_ack,

    input  data_t irq_vec,
    output logic  irq,

    output addr_t core_pc,
    output logic  core_rst
);

    logic  reg_pause_req;
    logic  reg_pause_ack;
    logic  seq_pause_req;
    logic  seq_pause_ack;
    logic  tgt_pause_req;
    logic  tgt_pause_ack;
    addr_t tgt_boot_addr;

    // Register side is paused before the sequencer
    pause_demux i_pause_demux (
        .seq     (seq),
        .arst_n  (arst_n),
        .up_req  (pause_req),
        .up_ack  (pause_ack),
        .dn0_req (reg_pause_req),
        .dn0_ack (reg_pause_ack),
        .dn1_req (seq_pause_req),
        .dn1_ack (seq_pause_ack)
    );

    syscfg_tgt #(
        .EN_BOOTSTRAP (1'b1),
        .EN_BOOT_ADDR (1'b1),
        .EN_IRQ       (1'b1)
    ) i_syscfg_tgt (
        .seq           (seq),
        .arst_n        (arst_n),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .pstrb         (pstrb),
        .pready        (pready),
        .prdata        (prdata),
        .pslverr       (pslverr),
        .reg_pause_req (reg_pause_req),
        .reg_pause_ack (reg_pause_ack),
        .seq_pause_req (seq_pause_req),
        .seq_pause_ack (seq_pause_ack),
        .irq_vec       (irq_vec),
        .tgt_rst       (core_rst),
        .tgt_pause_req (tgt_pause_req),
        .tgt_pause_ack (tgt_pause_ack),
        .tgt_boot_addr (tgt_boot_addr),
        .tgt_irq       (irq)
    );

    core_stub i_core_stub (
        .seq       (seq),
        .arst_n    (arst_n),
        .rst_req   (core_rst),
        .boot_addr (tgt_boot_addr),
        .pause_req (tgt_pause_req),
        .pause_ack (tgt_pause_ack),
        .pc        (core_pc)
    );

endmodule

// ==== hw/core_stub.sv ====
`include "syscfg_defs.svh"

module core_stub import syscfg_pkg::*; (
    input  logic  seq,
    input  logic  arst_n,

    input  logic  rst_req,
    input  addr_t boot_addr,

    input  logic  pause_req,
    output logic  pause_ack,

    output addr_t pc
);

    logic running;

    // Fetch stops once the pause is acknowledged
    assign running = !pause_ack;

    // Pause response one cycle behind the request
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            pause_ack <= 1'b1;
        end else begin
            pause_ack <= pause_req;
        end
    end

    // Fetch counter
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (rst_req) begin
            pc <= boot_addr;
        end else if (running) begin
            pc <= pc + `SYSCFG_PC_STEP;
        end
    end

endmodule

// ==== hw/syscfg_tgt.sv ====
`include "syscfg_defs.svh"

module syscfg_tgt import syscfg_pkg::*; #(
    parameter bit EN_BOOTSTRAP = 1'b0,
    parameter bit EN_BOOT_ADDR = 1'b0,
    parameter bit EN_IRQ       = 1'b0
) (
    input  logic    seq,
    input  logic    arst_n,

    input  addr_t   paddr,
    input  logic    psel,
    input  logic    penable,
    input  logic    pwrite,
    input  data_t   pwdata,
    input  strb_t   pstrb,
    output logic    pready,
    output data_t   prdata,
    output logic    pslverr,

    input  logic    reg_pause_req,
    output logic    reg_pause_ack,
    input  logic    seq_pause_req,
    output logic    seq_pause_ack,

    input  data_t   irq_vec,

    output logic    tgt_rst,
    output logic    tgt_pause_req,
    input  logic    tgt_pause_ack,
    output addr_t   tgt_boot_addr,
    output logic    tgt_irq
);

    localparam int BYTE_BITS = $clog2(`SYSCFG_DATA_WIDTH/8);

    action_t action;
    action_t state;
    logic    paused;
    logic    stopped;
    addr_t   bar;
    data_t   ier;

    data_t   mr;
    data_t   sr;
    addr_t   index;
    data_t   mask;
    logic    busy;

    assign mr = {{(`SYSCFG_DATA_WIDTH-`SYSCFG_ACT_WIDTH){1'b0}}, action};
    assign sr = {{(`SYSCFG_DATA_WIDTH-2){1'b0}}, stopped, paused};

    // Word index of the access
    assign index = paddr >> BYTE_BITS;

    always_comb begin
        for (int i = 0; i < `SYSCFG_DATA_WIDTH/8; i++) begin
            mask[i*8 +: 8] = pstrb[i] ? 8'hff : 8'h00;
        end
    end

    // MR and BAR are locked while an action is underway
    assign busy = (state != ACT_IDLE) || (action != ACT_IDLE);

    assign tgt_boot_addr = bar;
    assign tgt_irq       = |(irq_vec & ier);

    // APB register side
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            reg_pause_ack <= 1'b0;
            action        <= ACT_IDLE;
            bar           <= '0;
            ier           <= '0;
            prdata        <= '0;
            pready        <= 1'b0;
            pslverr       <= 1'b0;
        end else if (reg_pause_req && reg_pause_ack) begin
            // Requester sees pready low while paused
        end else if ((reg_pause_req != reg_pause_ack) && !pready) begin
            reg_pause_ack <= reg_pause_req;
        end else if (psel && !pready) begin
            pready <= 1'b1;
            case (index)
                `SYSCFG_IDX_SR: begin
                    if (pwrite) begin
                        pslverr <= 1'b1;
                    end else begin
                        prdata <= sr;
                    end
                end
                `SYSCFG_IDX_MR: begin
                    if (!pwrite) begin
                        prdata <= mr;
                    end else if (busy) begin
                        pslverr <= 1'b1;
                    end else if (pstrb[0]) begin
                        // Only the low byte carries the action
                        action <= action_t'(pwdata[`SYSCFG_ACT_WIDTH-1:0]);
                    end
                end
                `SYSCFG_IDX_BAR: begin
                    if (!EN_BOOT_ADDR) begin
                        pslverr <= 1'b1;
                    end else if (!pwrite) begin
                        prdata <= bar;
                    end else if (busy) begin
                        pslverr <= 1'b1;
                    end else begin
                        bar <= (pwdata & mask) | (bar & ~mask);
                    end
                end
                `SYSCFG_IDX_IER: begin
                    if (!EN_IRQ) begin
                        pslverr <= 1'b1;
                    end else if (!pwrite) begin
                        prdata <= ier;
                    end else begin
                        ier <= (pwdata & mask) | (ier & ~mask);
                    end
                end
                default: begin
                    pslverr <= 1'b1;
                end
            endcase
        end else if (psel && penable && pready) begin
            // Action self-clears as the transfer completes
            prdata  <= '0;
            pready  <= 1'b0;
            pslverr <= 1'b0;
            action  <= ACT_IDLE;
        end
    end

    // Action sequencer
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            seq_pause_ack <= 1'b0;
            tgt_rst       <= 1'b1;
            tgt_pause_req <= 1'b1;
            state         <= EN_BOOTSTRAP ? ACT_RESUME : ACT_IDLE;
            paused        <= 1'b1;
            stopped       <= 1'b1;
        end else if (seq_pause_req && seq_pause_ack) begin
            // Paused by system
        end else if ((seq_pause_req != seq_pause_ack) &&
                     (state == ACT_IDLE || seq_pause_ack) && action == ACT_IDLE) begin
            seq_pause_ack <= seq_pause_req;
        end else begin
            case (state)
                ACT_RESUME: begin
                    tgt_rst       <= 1'b0;
                    tgt_pause_req <= 1'b0;
                    if (!tgt_pause_req && !tgt_pause_ack) begin
                        paused  <= 1'b0;
                        stopped <= 1'b0;
                        state   <= ACT_IDLE;
                    end
                end
                ACT_PAUSE: begin
                    tgt_pause_req <= 1'b1;
                    if (tgt_pause_req && tgt_pause_ack) begin
                        paused <= 1'b1;
                        state  <= ACT_IDLE;
                    end
                end
                ACT_STOP, ACT_RESET: begin
                    tgt_pause_req <= 1'b1;
                    // Core held in reset once it has paused
                    if (tgt_pause_req && tgt_pause_ack) begin
                        tgt_rst <= 1'b1;
                        paused  <= 1'b1;
                        stopped <= 1'b1;
                        state   <= (state == ACT_RESET) ? ACT_RESUME : ACT_IDLE;
                    end
                end
                default: begin
                    state <= action;
                end
            endcase
        end
    end

endmodule

// ==== hw/pause_demux.sv ====
module pause_demux (
    input  logic seq,
    input  logic arst_n,

    input  logic up_req,
    output logic up_ack,

    output logic dn0_req,
    input  logic dn0_ack,

    output logic dn1_req,
    input  logic dn1_ack
);

    typedef enum logic [2:0] {
        ST_RUN,
        ST_PAUSE0,
        ST_PAUSE1,
        ST_PAUSED,
        ST_RESUME1,
        ST_RESUME0
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // Pause goes 0 then 1 and resume goes 1 then 0
    always_comb begin
        state_nxt = state;
        case (state)
            ST_RUN:     if (up_req)   state_nxt = ST_PAUSE0;
            ST_PAUSE0:  if (dn0_ack)  state_nxt = ST_PAUSE1;
            ST_PAUSE1:  if (dn1_ack)  state_nxt = ST_PAUSED;
            ST_PAUSED:  if (!up_req)  state_nxt = ST_RESUME1;
            ST_RESUME1: if (!dn1_ack) state_nxt = ST_RESUME0;
            ST_RESUME0: if (!dn0_ack) state_nxt = ST_RUN;
            default:    state_nxt = ST_RUN;
        endcase
    end

    assign dn0_req = (state == ST_PAUSE0) || (state == ST_PAUSE1) ||
                     (state == ST_PAUSED) || (state == ST_RESUME1);
    assign dn1_req = (state == ST_PAUSE1) || (state == ST_PAUSED);

    // Upstream ack only drops once the whole chain has resumed
    assign up_ack = (state == ST_PAUSED) || (state == ST_RESUME1) ||
                    (state == ST_RESUME0);

endmodule

// ==== hw/syscfg_pkg.sv ====
`include "syscfg_defs.svh"

package syscfg_pkg;

    // Bus words
    typedef logic [`SYSCFG_DATA_WIDTH-1:0] data_t;
    typedef logic [`SYSCFG_ADDR_WIDTH-1:0] addr_t;

    // One strobe bit per data byte
    typedef logic [`SYSCFG_DATA_WIDTH/8-1:0] strb_t;

    // Actions accepted by the maestro register
    typedef enum logic [`SYSCFG_ACT_WIDTH-1:0] {
        ACT_IDLE   = `SYSCFG_ACT_IDLE,
        ACT_RESUME = `SYSCFG_ACT_RESUME,
        ACT_PAUSE  = `SYSCFG_ACT_PAUSE,
        ACT_STOP   = `SYSCFG_ACT_STOP,
        ACT_RESET  = `SYSCFG_ACT_RESET
    } action_t;

endpackage

// ==== hw/syscfg_defs.svh ====
`ifndef SYSCFG_DEFS_SVH
`define SYSCFG_DEFS_SVH

// Bus widths
`define SYSCFG_ADDR_WIDTH 32
`define SYSCFG_DATA_WIDTH 32

// Register word indices
`define SYSCFG_IDX_SR  32'd0
`define SYSCFG_IDX_MR  32'd1
`define SYSCFG_IDX_BAR 32'd2
`define SYSCFG_IDX_IER 32'd3

// Maestro action codes
`define SYSCFG_ACT_WIDTH  4
`define SYSCFG_ACT_IDLE   4'd0
`define SYSCFG_ACT_RESUME 4'd1
`define SYSCFG_ACT_PAUSE  4'd2
`define SYSCFG_ACT_STOP   4'd3
`define SYSCFG_ACT_RESET  4'd4

// Core stub fetch increment
`define SYSCFG_PC_STEP 32'd4

`endif
